// ==== hw/dmm_reg_pkg.sv ====
//////////////////////////////////////////////////
// spi register map of the meter control FPGA
// a frame is one command byte then 32 data bits, MSB first
// only addresses 0 to 3 exist, the rest read as zero
//////////////////////////////////////////////////

package dmm_reg_pkg;

  //////////////////////////////////////////////////
  // frame layout

  // command byte, bit 7 selects write, bits 3:0 address
  localparam int CMD_W = 8;
  localparam int CMD_WR_BIT = 7;

  // data bits per frame, also the register width
  localparam int DATA_W = 32;

  // whole frame, command first
  localparam int FRAME_W = CMD_W + DATA_W;

  // address field in the low bits of the command byte
  localparam int ADDR_W = 4;

  //////////////////////////////////////////////////
  // register addresses

  // led scratch register, read back only
  localparam logic [ADDR_W-1:0] ADDR_LED = 4'd0;
  // bit 0 routes cs2 through to the 4094 chain
  localparam logic [ADDR_W-1:0] ADDR_SPI_MUX = 4'd1;
  // low 2 bits pick the conditioning output source
  localparam logic [ADDR_W-1:0] ADDR_MODE = 4'd2;
  // value shown on the outputs in direct mode
  localparam logic [ADDR_W-1:0] ADDR_DIRECT = 4'd3;

  // one register write, valid is a single clk strobe
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic              valid;
  } reg_write_t;

endpackage

// ==== hw/dmm_cond_pkg.sv ====
//////////////////////////////////////////////////
// conditioning output bundle and its source modes
// field order follows the board pin grouping, top bit first
//////////////////////////////////////////////////

package dmm_cond_pkg;

  // total bundle width, 4x4 mux lines + 8 monitor + 5 singles
  localparam int COND_W = 29;

  // one analog mux: enable on top, then address 2..0
  typedef struct packed {
    logic       en;
    logic [2:0] addr;
  } mux_ctl_t;

  //////////////////////////////////////////////////
  // bundle, from the top bit down
  typedef struct packed {
    logic       spi_interrupt;
    logic       meas_complete;
    logic       cmpr_latch;
    // adc current switches sw3..sw0
    logic [3:0] adc_sw;
    // monitor header mon7..mon0
    logic [7:0] monitor;
    logic       led;
    // signal pre-charge switch
    logic       precharge;
    mux_ctl_t   himux2;
    mux_ctl_t   himux;
    // lowest nibble
    mux_ctl_t   azmux;
  } cond_out_t;

  // output source, held in the low bits of the mode register
  typedef enum logic [1:0] {
    ZEROS   = 2'd0,
    ONES    = 2'd1,
    PATTERN = 2'd2,
    DIRECT  = 2'd3
  } mode_e;

endpackage

// ==== hw/spi_frame_rx.sv ====
//////////////////////////////////////////////////
// spi slave frame decoder, sampled by clk
// sck needs at least 4 clk high and 4 clk low
// write strobe comes SYNC_STAGES+1 clk after cs rises
// SYNC_STAGES must be 2 or more
//////////////////////////////////////////////////
`timescale 1ns/1ps

module spi_frame_rx #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              sck,
  input  logic                              cs,
  input  logic                              mosi,
  input  logic [dmm_reg_pkg::DATA_W-1:0]    rd_data,
  output dmm_reg_pkg::reg_write_t           wr,
  output logic [dmm_reg_pkg::ADDR_W-1:0]    rd_addr,
  output logic                              miso
);

  // counter saturates one past a full frame so long frames stay invalid
  localparam int CNT_W = $clog2(dmm_reg_pkg::FRAME_W + 2);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(dmm_reg_pkg::FRAME_W + 1);
  localparam logic [CNT_W-1:0] CNT_CMD = CNT_W'(dmm_reg_pkg::CMD_W);
  localparam logic [CNT_W-1:0] CNT_FRAME = CNT_W'(dmm_reg_pkg::FRAME_W);

  logic [SYNC_STAGES-1:0] sck_sync;
  logic [SYNC_STAGES-1:0] cs_sync;
  logic [SYNC_STAGES-1:0] mosi_sync;
  logic sck_s, cs_s, mosi_s;
  logic sck_d, cs_d;
  logic active, sck_rise, sck_fall, cs_rise;
  logic [CNT_W-1:0] bit_cnt;
  logic [dmm_reg_pkg::FRAME_W-1:0] frame_sr;
  logic [dmm_reg_pkg::DATA_W-1:0] tx_sr;
  logic wr_valid;
  logic [dmm_reg_pkg::ADDR_W-1:0] wr_addr;
  logic [dmm_reg_pkg::DATA_W-1:0] wr_data;

  //////////////////////////////////////////////////
  // pin synchronizers, cs idles high
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      mosi_sync <= '0;
      sck_d     <= 1'b0;
      cs_d      <= 1'b1;
    end
    else
    begin
      sck_sync  <= {sck_sync[SYNC_STAGES-2:0], sck};
      cs_sync   <= {cs_sync[SYNC_STAGES-2:0], cs};
      mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], mosi};
      sck_d     <= sck_s;
      cs_d      <= cs_s;
    end
  end

  assign sck_s  = sck_sync[SYNC_STAGES-1];
  assign cs_s   = cs_sync[SYNC_STAGES-1];
  assign mosi_s = mosi_sync[SYNC_STAGES-1];

  // edges only count inside a frame
  assign active   = ~cs_s;
  assign sck_rise = active & sck_s & ~sck_d;
  assign sck_fall = active & ~sck_s & sck_d;
  assign cs_rise  = cs_s & ~cs_d;

  // bits seen in this frame, cleared between frames
  always_ff @(posedge clk)
  begin
    if (!rst_n || !active)
      bit_cnt <= '0;
    else if (sck_rise && bit_cnt != CNT_MAX)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // mosi shift, command ends up in the top byte after 40 bits
  always_ff @(posedge clk)
  begin
    if (sck_rise)
      frame_sr <= {frame_sr[dmm_reg_pkg::FRAME_W-2:0], mosi_s};
  end

  // address is known at the 8th rising sck, low 3 bits already shifted in
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      rd_addr <= '0;
    else if (sck_rise && bit_cnt == CNT_CMD - 1'b1)
      rd_addr <= {frame_sr[dmm_reg_pkg::ADDR_W-2:0], mosi_s};
  end

  //////////////////////////////////////////////////
  // read data out, loaded on the 8th falling sck and
  // shifted on each later fall so the master samples on rise
  always_ff @(posedge clk)
  begin
    if (!rst_n || !active)
      tx_sr <= '0;
    else if (sck_fall && bit_cnt == CNT_CMD)
      // write frames send zeros back
      tx_sr <= frame_sr[dmm_reg_pkg::CMD_WR_BIT] ? '0 : rd_data;
    else if (sck_fall && bit_cnt > CNT_CMD)
      tx_sr <= {tx_sr[dmm_reg_pkg::DATA_W-2:0], 1'b0};
  end

  assign miso = tx_sr[dmm_reg_pkg::DATA_W-1];

  // write commits on cs rise, only for exactly 40 bits
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      wr_valid <= 1'b0;
    else
      wr_valid <= cs_rise && bit_cnt == CNT_FRAME
                  && frame_sr[dmm_reg_pkg::DATA_W + dmm_reg_pkg::CMD_WR_BIT];
  end

  always_ff @(posedge clk)
  begin
    if (cs_rise)
    begin
      wr_addr <= frame_sr[dmm_reg_pkg::DATA_W +: dmm_reg_pkg::ADDR_W];
      wr_data <= frame_sr[dmm_reg_pkg::DATA_W-1:0];
    end
  end

  always_comb
  begin
    wr.addr  = wr_addr;
    wr.data  = wr_data;
    wr.valid = wr_valid;
  end

  // one strobe per frame, cs must drop and rise again for the next
  a_wr_single_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    wr.valid |=> !wr.valid);

endmodule

// ==== hw/spi_reg_bank.sv ====
//////////////////////////////////////////////////
// control register bank and 4094 spi pass-through
// writes to unmapped addresses are dropped
// pass-through path is combinational from the pins
//////////////////////////////////////////////////
`timescale 1ns/1ps

module spi_reg_bank (
  input  logic                                clk,
  input  logic                                rst_n,
  input  dmm_reg_pkg::reg_write_t             wr,
  input  logic [dmm_reg_pkg::ADDR_W-1:0]      rd_addr,
  output logic [dmm_reg_pkg::DATA_W-1:0]      rd_data,
  output dmm_cond_pkg::mode_e                 mode,
  output logic [dmm_cond_pkg::COND_W-1:0]     direct,
  input  logic                                sck,
  input  logic                                mosi,
  input  logic                                cs2,
  input  logic                                u4094_din,
  input  logic                                frame_miso,
  output logic                                g4094_clk,
  output logic                                g4094_data,
  output logic                                g4094_strobe,
  output logic                                miso
);

  logic [dmm_reg_pkg::DATA_W-1:0] reg_led;
  logic [dmm_reg_pkg::DATA_W-1:0] reg_spi_mux;
  logic [dmm_reg_pkg::DATA_W-1:0] reg_mode;
  logic [dmm_reg_pkg::DATA_W-1:0] reg_direct;
  logic route_4094;

  //////////////////////////////////////////////////
  // register writes, one strobe from the frame decoder
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      reg_led     <= '0;
      reg_spi_mux <= '0;
      reg_mode    <= '0;
      reg_direct  <= '0;
    end
    else if (wr.valid)
    begin
      case (wr.addr)
        dmm_reg_pkg::ADDR_LED:     reg_led     <= wr.data;
        dmm_reg_pkg::ADDR_SPI_MUX: reg_spi_mux <= wr.data;
        dmm_reg_pkg::ADDR_MODE:    reg_mode    <= wr.data;
        dmm_reg_pkg::ADDR_DIRECT:  reg_direct  <= wr.data;
        // 4 to 15 have no storage
        default: ;
      endcase
    end
  end

  // read mux, full 32 bits back so the mcu can verify writes
  always_comb
  begin
    case (rd_addr)
      dmm_reg_pkg::ADDR_LED:     rd_data = reg_led;
      dmm_reg_pkg::ADDR_SPI_MUX: rd_data = reg_spi_mux;
      dmm_reg_pkg::ADDR_MODE:    rd_data = reg_mode;
      dmm_reg_pkg::ADDR_DIRECT:  rd_data = reg_direct;
      default:                   rd_data = '0;
    endcase
  end

  // only the low bits drive the output mux
  assign mode   = dmm_cond_pkg::mode_e'(reg_mode[1:0]);
  assign direct = reg_direct[dmm_cond_pkg::COND_W-1:0];

  //////////////////////////////////////////////////
  // 4094 chain shares sck/mosi/miso with the register port
  // route needs the enable bit and cs2 asserted
  assign route_4094 = reg_spi_mux[0] & ~cs2;

  // strobe is active high, held for the whole cs2 window
  assign g4094_strobe = route_4094;
  assign g4094_clk    = route_4094 & sck;
  assign g4094_data   = route_4094 & mosi;

  // chain tail feeds miso back while routed
  assign miso = route_4094 ? u4094_din : frame_miso;

  // chain must never latch while the route is off
  a_strobe_needs_route : assert property (@(posedge clk) disable iff (!rst_n)
    g4094_strobe |-> (reg_spi_mux[0] && !cs2));

endmodule

// ==== hw/cond_output_mux.sv ====
//////////////////////////////////////////////////
// source select for the 29 conditioning outputs
// pattern counter runs from reset in every mode
//////////////////////////////////////////////////
`timescale 1ns/1ps

module cond_output_mux (
  input  logic                              clk,
  input  logic                              rst_n,
  input  dmm_cond_pkg::mode_e               mode,
  input  logic [dmm_cond_pkg::COND_W-1:0]   direct,
  output dmm_cond_pkg::cond_out_t           cond
);

  logic [dmm_cond_pkg::COND_W-1:0] pattern_cnt;
  logic [dmm_cond_pkg::COND_W-1:0] cond_sel;

  //////////////////////////////////////////////////
  // free running test pattern, wraps at 2^29
  // bit 0 toggles azmux a0 every clk, handy on a scope
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      pattern_cnt <= '0;
    else
      pattern_cnt <= pattern_cnt + 1'b1;
  end

  // output source by mode
  always_comb
  begin
    case (mode)
      dmm_cond_pkg::ZEROS:   cond_sel = '0;
      dmm_cond_pkg::ONES:    cond_sel = '1;
      dmm_cond_pkg::PATTERN: cond_sel = pattern_cnt;
      dmm_cond_pkg::DIRECT:  cond_sel = direct;
      default:               cond_sel = '0;
    endcase
  end

  // flat vector onto the named bundle fields
  assign cond = dmm_cond_pkg::cond_out_t'(cond_sel);

  // mcu owns every pin in direct mode, checked against the register bank value
  a_direct_passes : assert property (@(posedge clk) disable iff (!rst_n)
    (mode == dmm_cond_pkg::DIRECT) |-> (cond == direct));

endmodule

// ==== hw/dmm_ctrl_top.sv ====
//////////////////////////////////////////////////
// meter control FPGA top, single clk domain
// cs selects the register port, cs2 the 4094 chain
// 4094 output enable is tied on
//////////////////////////////////////////////////
`timescale 1ns/1ps

module dmm_ctrl_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // mcu spi
  input  logic                      sck,
  input  logic                      cs,
  input  logic                      cs2,
  input  logic                      mosi,
  output logic                      miso,
  // 4094 chain
  input  logic                      u4094_din,
  output logic                      g4094_clk,
  output logic                      g4094_data,
  output logic                      g4094_strobe,
  output logic                      g4094_oe,
  // conditioning pins
  output dmm_cond_pkg::cond_out_t   cond
);

  dmm_reg_pkg::reg_write_t wr;
  logic [dmm_reg_pkg::ADDR_W-1:0] rd_addr;
  logic [dmm_reg_pkg::DATA_W-1:0] rd_data;
  logic frame_miso;
  dmm_cond_pkg::mode_e mode;
  logic [dmm_cond_pkg::COND_W-1:0] direct;

  // outputs enabled from power up
  assign g4094_oe = 1'b1;

  //////////////////////////////////////////////////
  // frame decoder, then registers, then output mux
  spi_frame_rx #(
    .SYNC_STAGES (SYNC_STAGES)
  ) spi_frame_rx_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .sck     (sck),
    .cs      (cs),
    .mosi    (mosi),
    .rd_data (rd_data),
    .wr      (wr),
    .rd_addr (rd_addr),
    .miso    (frame_miso)
  );

  spi_reg_bank spi_reg_bank_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr           (wr),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .mode         (mode),
    .direct       (direct),
    .sck          (sck),
    .mosi         (mosi),
    .cs2          (cs2),
    .u4094_din    (u4094_din),
    .frame_miso   (frame_miso),
    .g4094_clk    (g4094_clk),
    .g4094_data   (g4094_data),
    .g4094_strobe (g4094_strobe),
    .miso         (miso)
  );

  cond_output_mux cond_output_mux_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .mode   (mode),
    .direct (direct),
    .cond   (cond)
  );

endmodule

// ==== verif/tb_spi_tasks.svh ====
//////////////////////////////////////////////////
// spi master tasks and value compare for the testbench
// sck idles low, each half period lasts SCK_HALF clk
// expects clk, cs, sck, mosi, miso and the check counters in scope
//////////////////////////////////////////////////

// step forward n rising clk edges
task automatic wait_clks(input int n);
  repeat (n) @(posedge clk);
endtask

// one frame of nbits, command first, miso collected on each rise after the command
task automatic spi_frame(input logic [7:0] cmd, input logic [31:0] data,
                         input int nbits, output logic [31:0] rdata);
  logic [39:0] frame;
  frame = {cmd, data};
  rdata = '0;
  @(posedge clk);
  cs <= 1'b0;
  wait_clks(SCK_HALF);
  for (int i = 0; i < nbits; i++)
  begin
    // mosi set while sck is low, held through the rise
    mosi <= frame[39 - i];
    wait_clks(SCK_HALF);
    if (i >= 8)
      rdata = {rdata[30:0], miso};
    sck <= 1'b1;
    wait_clks(SCK_HALF);
    sck <= 1'b0;
  end
  wait_clks(SCK_HALF);
  cs <= 1'b1;
  mosi <= 1'b0;
  // covers the synchronizer, the strobe and the register update
  wait_clks(2 * SCK_HALF);
endtask

task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
  logic [31:0] ignored;
  spi_frame({4'b1000, addr}, data, 40, ignored);
endtask

task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
  spi_frame({4'b0000, addr}, 32'd0, 40, data);
endtask

// counts every compare, reports a mismatch at once
task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
  chk_cnt++;
  if (got !== exp)
  begin
    err_cnt++;
    $display("ERR %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
  end
endtask

// ==== verif/tb_dmm_ctrl.sv ====
//////////////////////////////////////////////////
// testbench for the meter control top
// register model held in exp_reg with one entry per mapped address
// random stimulus from a fixed seed
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_dmm_ctrl;

  localparam int SCK_HALF = 4;
  // spi frames per test sizing the watchdog
  localparam int FRAMES_REGS = 23;
  localparam int FRAMES_MODES = 7;
  localparam int FRAMES_PATTERN = 1;
  localparam int FRAMES_ROUTE = 2;
  localparam int FRAMES_ALL = FRAMES_REGS + FRAMES_MODES + FRAMES_PATTERN + FRAMES_ROUTE;
  localparam int WATCHDOG_CLKS = 2 * FRAMES_ALL * 400;

  logic clk, rst_n, sck, cs, cs2, mosi, u4094_din;
  logic miso, g4094_clk, g4094_data, g4094_strobe, g4094_oe;
  dmm_cond_pkg::cond_out_t cond;

  integer seed;
  int chk_cnt, err_cnt, test_cnt, chk_start, err_start;
  logic [31:0] exp_reg [0:3];
  logic [31:0] rnd, rdata;
  logic [3:0] addr;
  logic [28:0] prev, cur, diff;

  `include "tb_spi_tasks.svh"

  dmm_ctrl_top #(
    .SYNC_STAGES (2)
  ) dmm_ctrl_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .sck          (sck),
    .cs           (cs),
    .cs2          (cs2),
    .mosi         (mosi),
    .u4094_din    (u4094_din),
    .miso         (miso),
    .g4094_clk    (g4094_clk),
    .g4094_data   (g4094_data),
    .g4094_strobe (g4094_strobe),
    .g4094_oe     (g4094_oe),
    .cond         (cond)
  );

  always #50 clk = ~clk;

  // write through spi and keep the model in step
  task automatic write_tracked(input int idx, input logic [31:0] data);
    reg_write(4'(idx), data);
    exp_reg[idx] = data;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d checks, %0d errors", test_cnt, name,
             chk_cnt - chk_start, err_cnt - err_start);
    chk_start = chk_cnt;
    err_start = err_cnt;
  endtask

  // random pin levels on one edge and sampled half a period later
  task automatic drive_route_pins();
    @(posedge clk);
    rnd = $random(seed);
    sck <= rnd[0];
    mosi <= rnd[1];
    u4094_din <= rnd[2];
    @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // watchdog
  initial
  begin
    repeat (WATCHDOG_CLKS) @(posedge clk);
    $display("watchdog expired, the tests did not finish in time");
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // tests
  initial
  begin
    seed = 40688;
    clk = 1'b0;
    rst_n = 1'b0;
    sck = 1'b0;
    cs = 1'b1;
    cs2 = 1'b1;
    mosi = 1'b0;
    u4094_din = 1'b0;
    for (int r = 0; r < 4; r++)
      exp_reg[r] = '0;
    wait_clks(3);
    rst_n <= 1'b1;
    @(negedge clk);

    check_value(32'(cond), 32'd0, "cond after reset");
    check_value(32'(g4094_strobe), 32'd0, "strobe after reset");
    check_value(32'(g4094_clk), 32'd0, "4094 clk after reset");
    check_value(32'(g4094_data), 32'd0, "4094 data after reset");
    check_value(32'(miso), 32'd0, "miso after reset");
    check_value(32'(g4094_oe), 32'd1, "4094 oe tied high");
    end_test("reset values");

    // mapped registers then unmapped addresses then a short frame
    for (int a = 0; a < 4; a++)
    begin
      write_tracked(a, $random(seed));
      reg_read(4'(a), rdata);
      check_value(rdata, exp_reg[a], "read back after write");
    end
    for (int k = 0; k < 4; k++)
    begin
      addr = 4'(4 + $unsigned($random(seed)) % 12);
      reg_write(addr, $random(seed));
      reg_read(addr, rdata);
      check_value(rdata, 32'd0, "unmapped address read");
    end
    for (int a = 0; a < 4; a++)
    begin
      reg_read(4'(a), rdata);
      check_value(rdata, exp_reg[a], "register after unmapped writes");
    end
    // the data lsb of the frame before lands on the write bit of a 39 bit frame
    rnd = $random(seed);
    write_tracked(0, rnd | 32'd1);
    spi_frame({4'b1000, dmm_reg_pkg::ADDR_LED}, rnd, 39, rdata);
    reg_read(dmm_reg_pkg::ADDR_LED, rdata);
    check_value(rdata, exp_reg[0], "led after 39 bit frame");
    end_test("register access");

    // fixed modes and direct values
    write_tracked(2, 32'(dmm_cond_pkg::ZEROS));
    check_value(32'(cond), 32'd0, "cond in zeros mode");
    write_tracked(2, 32'(dmm_cond_pkg::ONES));
    check_value(32'(cond), {3'b000, {29{1'b1}}}, "cond in ones mode");
    write_tracked(2, 32'(dmm_cond_pkg::DIRECT));
    for (int k = 0; k < 4; k++)
    begin
      write_tracked(3, $random(seed));
      check_value(32'(cond), {3'b000, exp_reg[3][28:0]}, "cond in direct mode");
    end
    end_test("output modes");

    // pattern steps by one per clk with a 29 bit wrap
    write_tracked(2, 32'(dmm_cond_pkg::PATTERN));
    @(negedge clk);
    prev = cond;
    repeat (16)
    begin
      @(negedge clk);
      cur = cond;
      diff = cur - prev;
      check_value(32'(diff), 32'd1, "pattern step");
      prev = cur;
    end
    end_test("test pattern");

    // 4094 route on so the pins follow
    write_tracked(1, 32'd1);
    @(posedge clk);
    cs2 <= 1'b0;
    repeat (16)
    begin
      drive_route_pins();
      check_value(32'(g4094_strobe), 32'd1, "strobe with route on");
      check_value(32'(g4094_clk), 32'(sck), "4094 clk follows sck");
      check_value(32'(g4094_data), 32'(mosi), "4094 data follows mosi");
      check_value(32'(miso), 32'(u4094_din), "miso follows chain tail");
    end
    @(posedge clk);
    cs2 <= 1'b1;
    sck <= 1'b0;
    mosi <= 1'b0;
    // route off keeps the outputs low
    write_tracked(1, 32'd0);
    @(posedge clk);
    cs2 <= 1'b0;
    repeat (16)
    begin
      drive_route_pins();
      check_value(32'(g4094_strobe), 32'd0, "strobe with route off");
      check_value(32'(g4094_clk), 32'd0, "4094 clk with route off");
      check_value(32'(g4094_data), 32'd0, "4094 data with route off");
    end
    @(posedge clk);
    cs2 <= 1'b1;
    sck <= 1'b0;
    end_test("4094 pass-through");

    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+verif
hw/dmm_reg_pkg.sv
hw/dmm_cond_pkg.sv
hw/spi_frame_rx.sv
hw/spi_reg_bank.sv
hw/cond_output_mux.sv
hw/dmm_ctrl_top.sv
verif/tb_dmm_ctrl.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module tb_dmm_ctrl \
		-o Vtb_dmm_ctrl
	@out=$$(./obj_dir/Vtb_dmm_ctrl); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
